// ==== hw/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

	localparam int AUDIO_W    = 16; // One channel sample.
	localparam int SAMPLE_W   = 2 * AUDIO_W; // Stereo word, left in the upper half.
	localparam int FIFO_DEPTH = 16; // Words per FIFO.
	localparam int FIFO_AW    = 4; // FIFO pointer width.
	localparam int ADDR_W     = 3; // Host word address.
	localparam int BIT_CNT_W  = 5; // Counts 0 to AUDIO_W bits in one half.

	// Host register map.
	typedef enum logic [ADDR_W-1:0] {
		REG_DAC_LEFT  = 3'd0, // Left sample latch.
		REG_DAC_RIGHT = 3'd1, // Right sample, pushes the pair.
		REG_ADC_LEFT  = 3'd2, // Left half of the head word, pops.
		REG_ADC_RIGHT = 3'd3, // Right half saved by the last pop.
		REG_CMD       = 3'd4, // Bit 0 clears both FIFOs.
		REG_STATUS    = 3'd5 // Bit 0 DAC full, bit 1 ADC empty.
	} reg_addr_e;

	// Half-frame being shifted, coded as the lrc level.
	typedef enum logic {
		CHAN_RIGHT = 1'b0,
		CHAN_LEFT  = 1'b1
	} chan_e;

endpackage

`default_nettype wire

// ==== hw/sample_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_fifo import audio_pkg::*; (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                clear, // Synchronous flush.
	input  wire                push,
	input  wire [SAMPLE_W-1:0] push_data,
	input  wire                pop,
	output logic [SAMPLE_W-1:0] head, // Oldest word, valid when not empty.
	output logic               full,
	output logic               empty
);

	logic [SAMPLE_W-1:0] mem [FIFO_DEPTH]; // Storage array.
	logic [FIFO_AW-1:0]  wr_ptr; // Next free slot.
	logic [FIFO_AW-1:0]  rd_ptr; // Oldest word.
	logic [FIFO_AW:0]    count; // Occupancy, 0 to FIFO_DEPTH.
	logic                do_push;
	logic                do_pop;

	assign full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
	assign empty = (count == '0);

	assign do_push = push && !full; // Dropped when full.
	assign do_pop  = pop && !empty; // Ignored when empty.

	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Pointers wrap naturally at the depth.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clear) begin
			wr_ptr <= '0; // Flush in one cycle.
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither.
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/audio_dac.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_dac import audio_pkg::*; (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                clear,
	input  wire                push, // Stereo word from the host.
	input  wire [SAMPLE_W-1:0] word,
	output logic               full,
	input  wire                bclk, // Codec bit clock.
	input  wire                lrc, // High for left.
	output logic               dacdat
);

	logic [1:0]           bclk_sync; // Two-flop synchronizer.
	logic [1:0]           lrc_sync;
	logic                 bclk_d; // Edge register.
	logic                 lrc_d;
	logic                 bclk_fall;
	logic                 lrc_rise;
	logic                 lrc_fall;
	logic                 fifo_pop;
	logic [SAMPLE_W-1:0]  fifo_head;
	logic                 fifo_empty;
	logic [AUDIO_W-1:0]   left_word; // Head left half or silence.
	logic [AUDIO_W-1:0]   right_save; // Right half of the popped word.
	logic [AUDIO_W-1:0]   load_word;
	logic [AUDIO_W-1:0]   shift_q;
	logic [BIT_CNT_W-1:0] bits_left; // Bits still to send in this half.
	chan_e                chan;

	sample_fifo u_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.clear     (clear),
		.push      (push),
		.push_data (word),
		.pop       (fifo_pop),
		.head      (fifo_head),
		.full      (full),
		.empty     (fifo_empty)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bclk_sync <= '0;
			lrc_sync  <= '0;
			bclk_d    <= 1'b0;
			lrc_d     <= 1'b0;
		end else begin
			bclk_sync <= {bclk_sync[0], bclk};
			lrc_sync  <= {lrc_sync[0], lrc};
			bclk_d    <= bclk_sync[1];
			lrc_d     <= lrc_sync[1];
		end
	end

	assign bclk_fall = bclk_d && !bclk_sync[1];
	assign lrc_rise  = !lrc_d && lrc_sync[1]; // Start of a frame.
	assign lrc_fall  = lrc_d && !lrc_sync[1];

	assign fifo_pop  = lrc_rise && !fifo_empty; // Underrun sends zeros.
	assign left_word = fifo_empty ? '0 : fifo_head[SAMPLE_W-1 -: AUDIO_W];

	// Right half only follows a left half that was loaded.
	always_comb begin
		if (lrc_rise) begin
			load_word = left_word;
		end else if (chan == CHAN_LEFT) begin
			load_word = right_save;
		end else begin
			load_word = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (lrc_rise) begin
			right_save <= fifo_empty ? '0 : fifo_head[AUDIO_W-1:0];
		end
	end

	// Serializer, MSB first, next bit after each bclk fall.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			chan      <= CHAN_RIGHT;
			dacdat    <= 1'b0;
			shift_q   <= '0;
			bits_left <= '0;
		end else if (lrc_rise || lrc_fall) begin
			chan      <= lrc_rise ? CHAN_LEFT : CHAN_RIGHT;
			dacdat    <= load_word[AUDIO_W-1]; // MSB right after lrc edge.
			shift_q   <= {load_word[AUDIO_W-2:0], 1'b0};
			bits_left <= BIT_CNT_W'(AUDIO_W - 1);
		end else if (bclk_fall) begin
			if (bits_left != '0) begin
				dacdat    <= shift_q[AUDIO_W-1];
				shift_q   <= {shift_q[AUDIO_W-2:0], 1'b0};
				bits_left <= bits_left - 1'b1;
			end else begin
				dacdat <= 1'b0; // Pad to the next lrc edge.
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/audio_adc.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_adc import audio_pkg::*; (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                clear,
	input  wire                pop, // Host takes the head word.
	output logic [SAMPLE_W-1:0] word, // FIFO head.
	output logic               empty,
	input  wire                bclk,
	input  wire                lrc, // High for left.
	input  wire                adcdat
);

	logic [1:0]           bclk_sync;
	logic [1:0]           lrc_sync;
	logic [1:0]           dat_sync; // Same delay as bclk.
	logic                 bclk_d;
	logic                 lrc_d;
	logic                 bclk_rise;
	logic                 lrc_rise;
	logic                 lrc_fall;
	logic                 half_done; // All AUDIO_W bits taken.
	logic                 shift_en;
	logic [AUDIO_W-1:0]   shift_q;
	logic [AUDIO_W-1:0]   left_hold; // Completed left half.
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic                 left_ok; // Left half was complete.
	chan_e                chan;
	logic                 fifo_push;
	logic [SAMPLE_W-1:0]  push_word;
	logic                 fifo_full;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bclk_sync <= '0;
			lrc_sync  <= '0;
			dat_sync  <= '0;
			bclk_d    <= 1'b0;
			lrc_d     <= 1'b0;
		end else begin
			bclk_sync <= {bclk_sync[0], bclk};
			lrc_sync  <= {lrc_sync[0], lrc};
			dat_sync  <= {dat_sync[0], adcdat};
			bclk_d    <= bclk_sync[1];
			lrc_d     <= lrc_sync[1];
		end
	end

	assign bclk_rise = !bclk_d && bclk_sync[1]; // Sample point.
	assign lrc_rise  = !lrc_d && lrc_sync[1];
	assign lrc_fall  = lrc_d && !lrc_sync[1];
	assign half_done = (bit_cnt == BIT_CNT_W'(AUDIO_W));
	assign shift_en  = bclk_rise && !half_done && !lrc_rise && !lrc_fall;

	// Frame control and push request.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			chan      <= CHAN_RIGHT;
			bit_cnt   <= '0;
			left_ok   <= 1'b0;
			fifo_push <= 1'b0;
		end else if (clear) begin
			chan      <= CHAN_RIGHT; // Wait for a fresh frame.
			bit_cnt   <= '0;
			left_ok   <= 1'b0;
			fifo_push <= 1'b0;
		end else begin
			fifo_push <= 1'b0;
			if (lrc_rise) begin
				fifo_push <= left_ok && (chan == CHAN_RIGHT) && half_done;
				chan      <= CHAN_LEFT;
				bit_cnt   <= '0;
				left_ok   <= 1'b0;
			end else if (lrc_fall) begin
				left_ok <= (chan == CHAN_LEFT) && half_done;
				chan    <= CHAN_RIGHT;
				bit_cnt <= '0;
			end else if (shift_en) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// Deserializer data path.
	always_ff @(posedge clk) begin
		if (shift_en) begin
			shift_q <= {shift_q[AUDIO_W-2:0], dat_sync[1]};
		end
		if (lrc_fall) begin
			left_hold <= shift_q;
		end
		if (lrc_rise) begin
			push_word <= {left_hold, shift_q}; // Left in the upper half.
		end
	end

	sample_fifo u_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.clear     (clear),
		.push      (fifo_push && !fifo_full), // Frame dropped when full.
		.push_data (push_word),
		.pop       (pop),
		.head      (word),
		.full      (fifo_full),
		.empty     (empty)
	);

endmodule

`default_nettype wire

// ==== hw/audio_if.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_if import audio_pkg::*; (
	input  wire               clk,
	input  wire               rst_n,
	input  wire [ADDR_W-1:0]  address,
	input  wire               read, // One-cycle strobe.
	input  wire               write, // One-cycle strobe.
	input  wire [AUDIO_W-1:0] writedata,
	output logic [AUDIO_W-1:0] readdata, // Valid the cycle after read.
	input  wire               bclk,
	input  wire               daclrc,
	input  wire               adclrc,
	input  wire               adcdat,
	output logic              dacdat
);

	reg_addr_e           reg_sel;
	logic [AUDIO_W-1:0]  dac_left; // Left sample awaiting its pair.
	logic [AUDIO_W-1:0]  adc_right; // Right half of the last popped word.
	logic [AUDIO_W-1:0]  rd_mux;
	logic                fifo_clear;
	logic                dac_push;
	logic [SAMPLE_W-1:0] dac_word;
	logic                dac_full;
	logic                adc_pop;
	logic [SAMPLE_W-1:0] adc_word;
	logic                adc_empty;

	assign reg_sel = reg_addr_e'(address);

	// Writing the right sample pushes the pair, dropped when full.
	assign dac_push = write && (reg_sel == REG_DAC_RIGHT) && !dac_full;
	assign dac_word = {dac_left, writedata};

	// Left read pops the head word.
	assign adc_pop = read && (reg_sel == REG_ADC_LEFT) && !adc_empty;

	// Single-cycle clear pulse.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fifo_clear <= 1'b0;
		end else begin
			fifo_clear <= write && (reg_sel == REG_CMD) && writedata[0] && !fifo_clear;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dac_left <= '0;
		end else if (fifo_clear) begin
			dac_left <= '0;
		end else if (write && (reg_sel == REG_DAC_LEFT)) begin
			dac_left <= writedata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			adc_right <= '0;
		end else if (fifo_clear) begin
			adc_right <= '0;
		end else if (adc_pop) begin
			adc_right <= adc_word[AUDIO_W-1:0]; // Kept for the right read.
		end
	end

	// Read decode, unmapped addresses return zero.
	always_comb begin
		rd_mux = '0;
		case (reg_sel)
			REG_ADC_LEFT: begin
				if (!adc_empty) begin
					rd_mux = adc_word[SAMPLE_W-1 -: AUDIO_W];
				end
			end
			REG_ADC_RIGHT: rd_mux = adc_right;
			REG_STATUS: rd_mux = {{(AUDIO_W-2){1'b0}}, adc_empty, dac_full};
			default: rd_mux = '0; // DAC and CMD are write-only.
		endcase
	end

	// Holds until the next read.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			readdata <= '0;
		end else if (read) begin
			readdata <= rd_mux;
		end
	end

	audio_dac u_dac (
		.clk    (clk),
		.rst_n  (rst_n),
		.clear  (fifo_clear),
		.push   (dac_push),
		.word   (dac_word),
		.full   (dac_full),
		.bclk   (bclk),
		.lrc    (daclrc),
		.dacdat (dacdat)
	);

	audio_adc u_adc (
		.clk    (clk),
		.rst_n  (rst_n),
		.clear  (fifo_clear),
		.pop    (adc_pop),
		.word   (adc_word),
		.empty  (adc_empty),
		.bclk   (bclk),
		.lrc    (adclrc),
		.adcdat (adcdat)
	);

endmodule

`default_nettype wire

// ==== dv/audio_if_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_if_assert import audio_pkg::*; (
	input wire               clk,
	input wire               rst_n,
	input wire               fifo_clear,
	input wire               dac_push,
	input wire               dac_full,
	input wire               adc_pop,
	input wire               adc_empty,
	input wire               read,
	input wire [ADDR_W-1:0]  address,
	input wire [AUDIO_W-1:0] readdata
);

	// Clear is a single-cycle pulse.
	clear_pulse_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_clear |=> !fifo_clear)
		else $error("fifo_clear stayed high for two cycles");

	// Host pushes are gated by full.
	no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(dac_push && dac_full))
		else $error("dac_push while dac_full");

	// Host pops are gated by empty.
	no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!(adc_pop && adc_empty))
		else $error("adc_pop while adc_empty");

	// Addresses 6 and 7 are unmapped.
	unmapped_read_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(read && (address > 3'd5)) |=> (readdata == '0))
		else $error("unmapped read returned nonzero data");

endmodule

bind audio_if audio_if_assert u_assert (
	.clk        (clk),
	.rst_n      (rst_n),
	.fifo_clear (fifo_clear),
	.dac_push   (dac_push),
	.dac_full   (dac_full),
	.adc_pop    (adc_pop),
	.adc_empty  (adc_empty),
	.read       (read),
	.address    (address),
	.readdata   (readdata)
);

`default_nettype wire

// ==== dv/audio_if_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_if_tb import audio_pkg::*; ();

	localparam int HALF_BCLK  = 6; // clk cycles per bclk half-period.
	localparam int FRAME_CLKS = 2 * HALF_BCLK * SAMPLE_W; // 384 clk per frame.
	localparam int MAX_CYCLES = 104 * FRAME_CLKS; // About 40000, the tests run 29 frames.

	logic               clk;
	logic               rst_n;
	logic [ADDR_W-1:0]  address;
	logic               read;
	logic               write;
	logic [AUDIO_W-1:0] writedata;
	logic [AUDIO_W-1:0] readdata;
	logic               bclk;
	logic               daclrc;
	logic               adclrc;
	logic               adcdat;
	logic               dacdat;

	integer              seed = 76892; // Fixed random seed.
	int                  cycle_cnt;
	int                  checks;
	int                  errors;
	int                  test_errors;
	logic [SAMPLE_W-1:0] dac_exp[$]; // Pairs written by the host.
	logic [SAMPLE_W-1:0] dac_rx[$]; // Frames decoded from dacdat.
	logic [SAMPLE_W-1:0] adc_tx[$]; // Frames to send on adcdat.
	logic [SAMPLE_W-1:0] adc_exp[$];
	logic [AUDIO_W-1:0]  rd;

	audio_if dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.address   (address),
		.read      (read),
		.write     (write),
		.writedata (writedata),
		.readdata  (readdata),
		.bclk      (bclk),
		.daclrc    (daclrc),
		.adclrc    (adclrc),
		.adcdat    (adcdat),
		.dacdat    (dacdat)
	);

	always #10 clk = ~clk; // 20 ns period.

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic wait_clks(input int n);
		repeat (n) @(posedge clk);
		#2; // Drive point after the edge.
	endtask

	task automatic check_eq(input string name, input logic [SAMPLE_W-1:0] got,
			input logic [SAMPLE_W-1:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("%s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "errors", test_errors);
		test_errors = 0;
	endtask

	task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [AUDIO_W-1:0] data);
		address   = addr;
		writedata = data;
		write     = 1'b1;
		wait_clks(1);
		write = 1'b0;
	endtask

	task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [AUDIO_W-1:0] data);
		address = addr;
		read    = 1'b1;
		wait_clks(1);
		read = 1'b0;
		data = readdata; // Registered, valid now.
	endtask

	// Writes a random pair and records it.
	task automatic push_pair();
		logic [SAMPLE_W-1:0] pair;
		pair = $random(seed);
		write_reg(REG_DAC_LEFT, pair[SAMPLE_W-1 -: AUDIO_W]);
		write_reg(REG_DAC_RIGHT, pair[AUDIO_W-1:0]);
		dac_exp.push_back(pair);
	endtask

	task automatic clear_fifos();
		write_reg(REG_CMD, 16'h0001);
		wait_clks(1);
	endtask

	// Codec model: left-justified frames, lrc moves with bclk falls.
	task automatic run_frames(input int n);
		logic [SAMPLE_W-1:0] tx;
		logic [SAMPLE_W-1:0] rx;
		for (int f = 0; f < n; f++) begin
			tx = (adc_tx.size() != 0) ? adc_tx.pop_front() : '0;
			rx = '0;
			for (int b = 0; b < SAMPLE_W; b++) begin
				bclk = 1'b0;
				if (b == 0) begin
					daclrc = 1'b1; // Left half.
					adclrc = 1'b1;
				end else if (b == AUDIO_W) begin
					daclrc = 1'b0;
					adclrc = 1'b0;
				end
				adcdat = tx[SAMPLE_W-1-b];
				wait_clks(HALF_BCLK);
				bclk = 1'b1;
				rx[SAMPLE_W-1-b] = dacdat; // Stable since the fall.
				wait_clks(HALF_BCLK);
			end
			dac_rx.push_back(rx);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		address = '0;
		read = 1'b0;
		write = 1'b0;
		writedata = '0;
		bclk = 1'b1;
		daclrc = 1'b0;
		adclrc = 1'b0;
		adcdat = 1'b0;
		cycle_cnt = 0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		wait_clks(2);

		check_eq("readdata", readdata, '0);
		check_eq("dacdat", dacdat, '0);
		read_reg(REG_STATUS, rd);
		check_eq("status", rd, 32'h2); // ADC empty, DAC not full.
		read_reg(3'd6, rd);
		check_eq("readdata_unmapped", rd, '0);
		read_reg(3'd7, rd);
		check_eq("readdata_unmapped", rd, '0);
		end_test("reset");

		for (int i = 0; i < 4; i++) begin
			push_pair();
		end
		run_frames(6);
		for (int i = 0; i < 6; i++) begin
			check_eq("dac_frame", dac_rx.pop_front(), (i < 4) ? dac_exp.pop_front() : '0);
		end
		clear_fifos();
		end_test("playback");

		for (int i = 0; i < 5; i++) begin
			adc_tx.push_back($random(seed));
			adc_exp.push_back(adc_tx[i]);
		end
		adc_tx.push_back('0); // Trailing frame closes the fifth.
		run_frames(6);
		dac_rx.delete();
		wait_clks(8);
		for (int i = 0; i < 5; i++) begin
			read_reg(REG_ADC_LEFT, rd);
			check_eq("adc_left", rd, adc_exp[i][SAMPLE_W-1 -: AUDIO_W]);
			read_reg(REG_ADC_RIGHT, rd);
			check_eq("adc_right", rd, adc_exp[i][AUDIO_W-1:0]);
		end
		read_reg(REG_ADC_LEFT, rd);
		check_eq("adc_left_empty", rd, '0);
		clear_fifos();
		end_test("capture");

		for (int i = 0; i < 17; i++) begin
			push_pair();
			adc_tx.push_back($random(seed)); // Fills the capture FIFO too.
		end
		read_reg(REG_STATUS, rd);
		check_eq("status_full", rd[0], 1'b1);
		run_frames(17);
		for (int i = 0; i < 17; i++) begin
			check_eq("dac_frame", dac_rx.pop_front(), (i < 16) ? dac_exp[i] : '0);
		end
		dac_exp.delete();
		end_test("full_drop");

		for (int i = 0; i < FIFO_DEPTH; i++) begin
			push_pair(); // Playback FIFO full, capture FIFO still holds frames.
		end
		read_reg(REG_STATUS, rd);
		check_eq("status_filled", rd, 32'h1);
		clear_fifos();
		dac_exp.delete();
		read_reg(REG_STATUS, rd);
		check_eq("status_cleared", rd, 32'h2);
		read_reg(REG_ADC_LEFT, rd);
		check_eq("adc_left_cleared", rd, '0);
		read_reg(REG_ADC_RIGHT, rd);
		check_eq("adc_right_cleared", rd, '0);
		end_test("clear");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/audio_pkg.sv
hw/sample_fifo.sv
hw/audio_dac.sv
hw/audio_adc.sv
hw/audio_if.sv
dv/audio_if_assert.sv
dv/audio_if_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the audio_if testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module audio_if_tb \
	-f flist.f -o sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim > sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && { echo "Simulation reported failure"; exit 1; } || exit 0
